//--- src.f
+incdir+include
hw/soc_pkg.sv
hw/system_bus_decoder.sv
hw/sram_memory.sv
hw/peripheral_bus.sv
hw/gpio_controller.sv
hw/soc_top.sv
testbench/tb_clock.sv
testbench/soc_tb.sv

//--- run.sh
#!/bin/sh
# build and run the soc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module soc_tb -o soc_sim

out=$(./obj_dir/soc_sim)
echo "$out"

# pass only if the pass line shows up
echo "$out" | grep -qx "Everything OK"
echo "simulation passed"

//--- testbench/soc_tb.sv
// soc testbench, random bus traffic checked against a memory and gpio model, run as the top
`timescale 1ns/10ps
`default_nettype none

`include "soc_config.svh"

module soc_tb;

    localparam int N_RAND = 400;
    localparam int CLK_NS = 4;
    // watchdog limit from the transaction count
    localparam int WD_NS = (N_RAND + 50) * CLK_NS * 4;
    // memory words in use, spread over the array
    localparam int N_SLOT = 16;
    localparam logic [15:0] SEED = 16'd36714;
    localparam logic [`XLEN-1:0] MEM_LO = `MEM_BASE;
    localparam logic [`XLEN-1:0] PER_LO = `PER_BASE;

    logic              clk;
    logic              rst_n;
    soc_pkg::bus_req_t bus_req;
    soc_pkg::bus_rsp_t bus_rsp;
    logic [`GDW-1:0]   gpio_o;
    logic [`GDW-1:0]   gpio_e;
    logic [`GDW-1:0]   gpio_i;

    ////////////////////
    // model state
    ////////////////////

    logic [`XLEN-1:0]  mem_mdl [0:2**`MEM_ADR-1];
    logic [`GDW-1:0]   out_mdl;
    logic [`GDW-1:0]   ena_mdl;
    // register values one cycle behind, pins follow them
    logic [`GDW-1:0]   out_stg;
    logic [`GDW-1:0]   ena_stg;
    logic [`GDW-1:0]   inp_mdl;
    // cycles since gpio_i last changed
    int                inp_age;
    // answer due in the next cycle
    soc_pkg::bus_rsp_t exp_rsp;
    logic [15:0]       lfsr;
    int                checks;
    int                errors;
    soc_pkg::bus_req_t req;

    tb_clock #(.PERIOD_NS(CLK_NS)) u_clock (.clk(clk));

    soc_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .gpio_o  (gpio_o),
        .gpio_e  (gpio_e),
        .gpio_i  (gpio_i)
    );

    ////////////////////
    // random numbers
    ////////////////////

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    ////////////////////
    // request helpers
    ////////////////////

    function automatic soc_pkg::bus_req_t make_req(input logic wen, input logic [`XLEN-1:0] adr,
                                                   input logic [1:0] siz,
                                                   input logic [`XLEN-1:0] wdt);
        soc_pkg::bus_req_t r;
        r.vld = 1'b1;
        r.wen = wen;
        r.adr = adr;
        r.siz = siz;
        r.wdt = wdt;
        return r;
    endfunction

    // slot k lands at word 65*k
    function automatic logic [`XLEN-1:0] slot_adr(input int k, input int o);
        return MEM_LO + `XLEN'(k * 260 + o);
    endfunction

    function automatic logic [`XLEN-1:0] per_adr(input int o);
        return PER_LO + `XLEN'(o);
    endfunction

    // fill pattern from every address bit
    function automatic logic [`XLEN-1:0] fill_word(input logic [`XLEN-1:0] adr);
        return {adr[15:0], adr[31:16]} ^ 32'h3c96_a5f0;
    endfunction

    // new input value, held from this falling edge on
    task automatic drive_inp(input logic [`GDW-1:0] v);
        gpio_i = v;
        inp_mdl = v;
        inp_age = 0;
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // expected answer from the address map and error rules, state updated in order
    task automatic predict(input soc_pkg::bus_req_t r, output soc_pkg::bus_rsp_t rsp);
        logic [7:0]          ofs;
        logic [`MEM_ADR-1:0] idx;
        int                  lo;
        int                  nb;
        logic                ok;
        rsp = '0;
        rsp.vld = r.vld;
        ok = 1'b0;
        lo = int'(r.adr[1:0]);
        nb = 1 << r.siz;
        if (!r.vld || r.siz == 2'd3 || (lo % nb) != 0) begin
            ok = 1'b0;
        end else if (r.adr[`XLEN-1:`MEM_ADR+2] == MEM_LO[`XLEN-1:`MEM_ADR+2]) begin
            ok = 1'b1;
            idx = r.adr[`MEM_ADR+1:2];
            if (r.wen) begin
                // lanes from the low address bits, data in its own lanes
                for (int b = lo; b < lo + nb; b++) begin
                    mem_mdl[idx][8*b +: 8] = r.wdt[8*b +: 8];
                end
            end else begin
                rsp.rdt = mem_mdl[idx];
            end
        end else if (r.adr[`XLEN-1:`PER_ADR] == PER_LO[`XLEN-1:`PER_ADR]) begin
            ofs = r.adr[7:0];
            // word access to an existing register, input register read only
            ok = (r.siz == 2'd2) && (ofs == `GPIO_OUT || ofs == `GPIO_ENA ||
                                     (ofs == `GPIO_INP && !r.wen));
            if (ok && r.wen) begin
                if (ofs == `GPIO_OUT) begin
                    out_mdl = r.wdt;
                end else begin
                    ena_mdl = r.wdt;
                end
            end else if (ok) begin
                case (ofs)
                    `GPIO_OUT: rsp.rdt = out_mdl;
                    `GPIO_ENA: rsp.rdt = ena_mdl;
                    default: rsp.rdt = inp_mdl;
                endcase
            end
        end
        rsp.err = r.vld && !ok;
    endtask

    ////////////////////
    // checks
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s exp %h got %h", name, exp, got);
        end
    endtask

    // one cycle, check the answer to the last request, then drive the next
    task automatic step(input soc_pkg::bus_req_t r);
        @(negedge clk);
        check_value("bus_rsp.vld", 32'(exp_rsp.vld), 32'(bus_rsp.vld));
        if (exp_rsp.vld) begin
            check_value("bus_rsp.err", 32'(exp_rsp.err), 32'(bus_rsp.err));
            check_value("bus_rsp.rdt", exp_rsp.rdt, bus_rsp.rdt);
        end
        // pins change one edge after the registered request
        check_value("gpio_o", out_stg, gpio_o);
        check_value("gpio_e", ena_stg, gpio_e);
        out_stg = out_mdl;
        ena_stg = ena_mdl;
        bus_req = r;
        predict(r, exp_rsp);
        inp_age++;
    endtask

    // mix of memory, gpio, error and idle cycles
    task automatic rand_req(output soc_pkg::bus_req_t r);
        logic [2:0] cat;
        logic [1:0] pick;
        int         siz;
        int         o;
        cat = 3'(rand_bits(3));
        pick = 2'(rand_bits(2));
        r = make_req(rand_bits(1) != 0, '0, 2'd2, rand_bits(32));
        case (cat)
            3'd0, 3'd1, 3'd2: begin
                // aligned memory access of any size
                siz = int'(rand_bits(2)) % 3;
                o = int'(rand_bits(2));
                o = o - (o % (1 << siz));
                r.adr = slot_adr(int'(rand_bits(4)), o);
                r.siz = 2'(siz);
            end
            3'd3: begin
                if (pick[1] && inp_age >= 3) begin
                    r.adr = per_adr(int'(`GPIO_INP));
                    r.wen = 1'b0;
                end else begin
                    r.adr = per_adr(pick[0] ? int'(`GPIO_ENA) : int'(`GPIO_OUT));
                end
            end
            3'd4: begin
                // narrow gpio, input register write, unused gpio word
                case (pick)
                    2'd0: r.siz = 2'd0;
                    2'd1: r.adr = per_adr(4);
                    2'd2: r.adr = per_adr(8);
                    default: r.adr = per_adr(4 * (3 + int'(rand_bits(4)) % 13));
                endcase
                r.siz = (pick == 2'd1) ? 2'd1 : r.siz;
                r.wen = (pick == 2'd2) ? 1'b1 : r.wen;
                r.adr = (pick == 2'd0) ? per_adr(0) : r.adr;
            end
            // uart window and the unmapped rest
            3'd5: r.adr = per_adr(64 + 4 * int'(rand_bits(5)));
            3'd6: begin
                case (pick)
                    2'd0: r = make_req(r.wen, slot_adr(int'(rand_bits(4)), 1), 2'd1, r.wdt);
                    2'd1: r = make_req(r.wen, slot_adr(int'(rand_bits(4)), 2), 2'd2, r.wdt);
                    2'd2: r = make_req(r.wen, slot_adr(int'(rand_bits(4)), 0), 2'd3, r.wdt);
                    // top bit clear, outside both windows
                    default: r.adr = rand_bits(32) & 32'h7fff_fffc;
                endcase
            end
            default: begin
                r.vld = 1'b0;
                drive_inp(rand_bits(32));
            end
        endcase
    endtask

    ////////////////////
    // sequence
    ////////////////////

    initial begin
        lfsr = SEED;
        checks = 0;
        errors = 0;
        rst_n = 1'b0;
        bus_req = '0;
        gpio_i = '0;
        inp_mdl = '0;
        inp_age = 0;
        out_mdl = '0;
        ena_mdl = '0;
        out_stg = '0;
        ena_stg = '0;
        exp_rsp = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // reset values
        check_value("bus_rsp.vld", 32'h0, 32'(bus_rsp.vld));
        check_value("gpio_o", 32'h0, gpio_o);
        check_value("gpio_e", 32'h0, gpio_e);
        for (int k = 0; k < N_SLOT; k++) begin
            step(make_req(1'b1, slot_adr(k, 0), 2'd2, fill_word(slot_adr(k, 0))));
        end
        // byte and half merged into filled words
        for (int k = 0; k < 4; k++) begin
            step(make_req(1'b1, slot_adr(k, k), 2'd0, rand_bits(32)));
            step(make_req(1'b1, slot_adr(k, 2 * (k % 2)), 2'd1, rand_bits(32)));
            step(make_req(1'b0, slot_adr(k, 0), 2'd2, '0));
        end
        // gpio registers and the synchronized input
        step(make_req(1'b1, per_adr(0), 2'd2, rand_bits(32)));
        step(make_req(1'b1, per_adr(4), 2'd2, rand_bits(32)));
        step(make_req(1'b0, per_adr(0), 2'd2, '0));
        step(make_req(1'b0, per_adr(4), 2'd2, '0));
        drive_inp(rand_bits(32));
        repeat (3) step('0);
        step(make_req(1'b0, per_adr(8), 2'd2, '0));
        // each error kind once, all writes so state must hold
        step(make_req(1'b1, slot_adr(1, 1), 2'd1, rand_bits(32)));
        step(make_req(1'b1, slot_adr(2, 2), 2'd2, rand_bits(32)));
        step(make_req(1'b1, slot_adr(3, 0), 2'd3, rand_bits(32)));
        step(make_req(1'b1, 32'h0000_1000, 2'd2, rand_bits(32)));
        step(make_req(1'b1, MEM_LO + 32'h1000, 2'd2, rand_bits(32)));
        step(make_req(1'b1, per_adr(64), 2'd2, rand_bits(32)));
        step(make_req(1'b1, per_adr(128), 2'd2, rand_bits(32)));
        step(make_req(1'b1, per_adr(0), 2'd0, rand_bits(32)));
        step(make_req(1'b1, per_adr(8), 2'd2, rand_bits(32)));
        for (int k = 1; k < 4; k++) begin
            step(make_req(1'b0, slot_adr(k, 0), 2'd2, '0));
        end
        step(make_req(1'b0, per_adr(0), 2'd2, '0));
        step(make_req(1'b0, per_adr(4), 2'd2, '0));
        // back to back random traffic
        for (int n = 0; n < N_RAND; n++) begin
            rand_req(req);
            step(req);
        end
        // drain the last answer and pin update
        repeat (2) step('0);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WD_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WD_NS);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// testbench clock source, free running from time zero, instanced by the testbench top
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    // clock period in ns
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    // low for the first half period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- hw/soc_top.sv
// soc top level, system bus port in, decoder, memory, peripheral bus and gpio wired together
`timescale 1ns/10ps
`default_nettype none

`include "soc_config.svh"

module soc_top (
    // system
    input  wire logic              clk,
    input  wire logic              rst_n,
    // system bus, driven by the master
    input  wire soc_pkg::bus_req_t bus_req,
    output soc_pkg::bus_rsp_t      bus_rsp,
    // gpio pins
    output logic [`GDW-1:0]        gpio_o,
    output logic [`GDW-1:0]        gpio_e,
    input  wire logic [`GDW-1:0]   gpio_i
);

    ////////////////////
    // internal buses
    ////////////////////

    // memory, one cycle response
    soc_pkg::bus_req_t mem_req;
    soc_pkg::bus_rsp_t mem_rsp;
    // peripheral bus, before the request register
    soc_pkg::bus_req_t per_req;
    soc_pkg::bus_rsp_t per_rsp;
    // gpio, after the request register
    soc_pkg::bus_req_t gpio_req;
    soc_pkg::bus_rsp_t gpio_rsp;

    ////////////////////
    // instances
    ////////////////////

    system_bus_decoder u_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (bus_req),
        .cpu_rsp (bus_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .per_req (per_req),
        .per_rsp (per_rsp)
    );

    sram_memory u_memory (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

    peripheral_bus u_peripheral (
        .clk      (clk),
        .rst_n    (rst_n),
        .sys_req  (per_req),
        .sys_rsp  (per_rsp),
        .gpio_req (gpio_req),
        .gpio_rsp (gpio_rsp)
    );

    gpio_controller u_gpio (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (gpio_req),
        .rsp    (gpio_rsp),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i)
    );

endmodule

`default_nettype wire

//--- hw/gpio_controller.sv
// gpio controller, output and enable registers plus a synchronized input, word access only
`timescale 1ns/10ps
`default_nettype none

`include "soc_config.svh"

module gpio_controller (
    // system
    input  wire logic              clk,
    input  wire logic              rst_n,
    // bus, zero delay
    input  wire soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t      rsp,
    // pins
    output logic [`GDW-1:0]        gpio_o,
    output logic [`GDW-1:0]        gpio_e,
    input  wire logic [`GDW-1:0]   gpio_i
);

    // widths as parameters for casts
    localparam int unsigned XW = `XLEN;
    localparam int unsigned GW = `GDW;

    // synchronizer stages
    logic [GW-1:0]       inp_m;
    logic [GW-1:0]       inp_s;
    logic [`PER_ADR-1:0] ofs;
    // selected register
    logic [GW-1:0]       rd_reg;

    assign ofs = req.adr[`PER_ADR-1:0];

    ////////////////////
    // registers
    ////////////////////

    // written on the edge after the registered request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_o <= '0;
            gpio_e <= '0;
        end else if (req.vld && req.wen) begin
            case (ofs)
                `GPIO_OUT: gpio_o <= GW'(req.wdt);
                `GPIO_ENA: gpio_e <= GW'(req.wdt);
                default: ;
            endcase
        end
    end

    // two flop input synchronizer
    always_ff @(posedge clk) begin
        inp_m <= gpio_i;
        inp_s <= inp_m;
    end

    ////////////////////
    // read back
    ////////////////////

    always_comb begin
        case (ofs)
            `GPIO_OUT: rd_reg = gpio_o;
            `GPIO_ENA: rd_reg = gpio_e;
            `GPIO_INP: rd_reg = inp_s;
            default: rd_reg = '0;
        endcase
    end

    // same cycle answer, zero data on writes
    always_comb begin
        rsp.vld = req.vld;
        rsp.err = 1'b0;
        rsp.rdt = (req.vld && !req.wen) ? XW'(rd_reg) : '0;
    end

endmodule

`default_nettype wire

//--- hw/peripheral_bus.sv
// peripheral bus, registers the request and decodes the gpio and reserved uart windows
`timescale 1ns/10ps
`default_nettype none

`include "soc_config.svh"

module peripheral_bus (
    // system
    input  wire logic              clk,
    input  wire logic              rst_n,
    // system bus side
    input  wire soc_pkg::bus_req_t sys_req,
    output soc_pkg::bus_rsp_t      sys_rsp,
    // gpio side
    output soc_pkg::bus_req_t      gpio_req,
    input  wire soc_pkg::bus_rsp_t gpio_rsp
);

    // registered request, peripherals answer with zero delay
    soc_pkg::bus_req_t   req_q;
    // offset inside the peripheral window
    logic [`PER_ADR-1:0] ofs;
    // existing gpio register for this direction
    logic                reg_ok;
    // access goes to gpio
    logic                gpio_ok;

    ////////////////////
    // request register
    ////////////////////

    // payload is not reset, only vld
    always_ff @(posedge clk) begin
        req_q <= sys_req;
        if (!rst_n) begin
            req_q.vld <= 1'b0;
        end
    end

    assign ofs = req_q.adr[`PER_ADR-1:0];

    ////////////////////
    // offset decode
    ////////////////////

    // input register is read only
    always_comb begin
        case (ofs)
            `GPIO_OUT, `GPIO_ENA: reg_ok = 1'b1;
            `GPIO_INP: reg_ok = !req_q.wen;
            default: reg_ok = 1'b0;
        endcase
    end

    // gpio takes word accesses only
    always_comb begin
        case (ofs[`PER_ADR-1:`PER_ADR-2])
            `PER_GPIO: gpio_ok = reg_ok && (req_q.siz == 2'd2);
            // uart not built, window stays reserved
            `PER_UART: gpio_ok = 1'b0;
            // rest of the window unmapped
            default: gpio_ok = 1'b0;
        endcase
    end

    always_comb begin
        gpio_req     = req_q;
        gpio_req.vld = req_q.vld && gpio_ok;
    end

    ////////////////////
    // response
    ////////////////////

    // gpio answer or an error, erroring writes never reach gpio
    always_comb begin
        if (gpio_ok) begin
            sys_rsp = gpio_rsp;
        end else begin
            sys_rsp.vld = req_q.vld;
            sys_rsp.err = req_q.vld;
            sys_rsp.rdt = '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/sram_memory.sv
// word wide data memory with byte writes, log-size requests, read data one cycle later
`timescale 1ns/10ps
`default_nettype none

`include "soc_config.svh"

module sram_memory (
    // system
    input  wire logic              clk,
    input  wire logic              rst_n,
    // bus
    input  wire soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t      rsp
);

    // byte enable width and byte offset bits
    localparam int unsigned BEW = `XLEN/8;
    localparam int unsigned OFW = $clog2(BEW);

    // storage, contents not reset
    logic [`XLEN-1:0]    mem [0:2**`MEM_ADR-1];
    // word index and byte offset
    logic [`MEM_ADR-1:0] idx;
    logic [OFW-1:0]      ofs;
    logic [BEW-1:0]      ben;
    logic                vld_q;
    logic [`XLEN-1:0]    rdt_q;

    assign idx = req.adr[`MEM_ADR+OFW-1:OFW];
    assign ofs = req.adr[OFW-1:0];

    ////////////////////
    // log size to byte enables
    ////////////////////

    // little endian, lanes follow the low address bits
    always_comb begin
        case (req.siz)
            2'd0: ben = BEW'(1) << ofs;
            2'd1: ben = BEW'(3) << ofs;
            default: ben = '1;
        endcase
    end

    ////////////////////
    // write and read
    ////////////////////

    // write lands on the request edge
    always_ff @(posedge clk) begin
        if (req.vld && req.wen) begin
            for (int b = 0; b < BEW; b++) begin
                if (ben[b]) begin
                    mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
                end
            end
        end
    end

    // whole aligned word, zero for writes
    always_ff @(posedge clk) begin
        if (req.vld) begin
            rdt_q <= req.wen ? '0 : mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= req.vld;
        end
    end

    always_comb begin
        rsp.vld = vld_q;
        // memory never errors, decoder filtered the request
        rsp.err = 1'b0;
        rsp.rdt = rdt_q;
    end

    // every write lane stays inside the word
    // holds only if the decoder let no misaligned access through
    a_wr_ben: assert property (@(posedge clk) disable iff (!rst_n)
        (req.vld && req.wen) |-> ((ben != '0) && ($countones(ben) == (1 << req.siz))));

endmodule

`default_nettype wire

//--- hw/system_bus_decoder.sv
// system bus decoder inside soc_top that routes master requests to memory, peripherals or an error answer
`timescale 1ns/10ps
`default_nettype none

`include "soc_config.svh"

module system_bus_decoder (
    // system
    input  wire logic              clk,
    input  wire logic              rst_n,
    // master side
    input  wire soc_pkg::bus_req_t cpu_req,
    output soc_pkg::bus_rsp_t      cpu_rsp,
    // memory side
    output soc_pkg::bus_req_t      mem_req,
    input  wire soc_pkg::bus_rsp_t mem_rsp,
    // peripheral side
    output soc_pkg::bus_req_t      per_req,
    input  wire soc_pkg::bus_rsp_t per_rsp
);

    // window bases
    localparam logic [`XLEN-1:0] MEM_LO = `MEM_BASE;
    localparam logic [`XLEN-1:0] PER_LO = `PER_BASE;
    // byte offset bits inside a word
    localparam int unsigned OFW = $clog2(`XLEN/8);

    // misaligned for its size
    logic              mis;
    logic              hit_mem;
    logic              hit_per;
    soc_pkg::bus_sel_t sel;
    // request and target of the previous cycle
    logic              req_q;
    soc_pkg::bus_sel_t sel_q;

    ////////////////////
    // request decode
    ////////////////////

    always_comb begin
        case (cpu_req.siz)
            2'd0: mis = 1'b0;
            2'd1: mis = cpu_req.adr[0];
            2'd2: mis = |cpu_req.adr[OFW-1:0];
            // 8 byte access does not exist on this bus
            default: mis = 1'b1;
        endcase
    end

    // upper address bits against window bases
    assign hit_mem = cpu_req.adr[`XLEN-1:`MEM_ADR+OFW] == MEM_LO[`XLEN-1:`MEM_ADR+OFW];
    assign hit_per = cpu_req.adr[`XLEN-1:`PER_ADR] == PER_LO[`XLEN-1:`PER_ADR];

    // alignment wins over the address match
    always_comb begin
        if (mis) begin
            sel = soc_pkg::SEL_ERR;
        end else if (hit_mem) begin
            sel = soc_pkg::SEL_MEM;
        end else if (hit_per) begin
            sel = soc_pkg::SEL_PER;
        end else begin
            sel = soc_pkg::SEL_ERR;
        end
    end

    // payload to both targets with vld only for the chosen one
    always_comb begin
        mem_req     = cpu_req;
        mem_req.vld = cpu_req.vld && (sel == soc_pkg::SEL_MEM);
        per_req     = cpu_req;
        per_req.vld = cpu_req.vld && (sel == soc_pkg::SEL_PER);
    end

    ////////////////////
    // response merge
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
            sel_q <= soc_pkg::SEL_ERR;
        end else begin
            req_q <= cpu_req.vld;
            sel_q <= sel;
        end
    end

    always_comb begin
        case (sel_q)
            soc_pkg::SEL_MEM: cpu_rsp = mem_rsp;
            soc_pkg::SEL_PER: cpu_rsp = per_rsp;
            // own error answer since no target saw the request
            default: begin
                cpu_rsp.vld = req_q;
                cpu_rsp.err = req_q;
                cpu_rsp.rdt = '0;
            end
        endcase
    end

    // a target only answers a request routed to it one cycle before
    a_rsp_target: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_rsp.vld || per_rsp.vld) |->
            (req_q && (!mem_rsp.vld || (sel_q == soc_pkg::SEL_MEM))
                   && (!per_rsp.vld || (sel_q == soc_pkg::SEL_PER))));

endmodule

`default_nettype wire

//--- hw/soc_pkg.sv
// bus request/response structs and target select type, referenced by scoped name
`default_nettype none

`include "soc_config.svh"

package soc_pkg;

    ////////////////////
    // bus request
    ////////////////////

    typedef struct packed {
        // transfer valid
        logic              vld;
        // write enable, read when low
        logic              wen;
        // byte address
        logic [`XLEN-1:0]  adr;
        // log2 of byte count
        // 0 byte, 1 half, 2 word
        logic [1:0]        siz;
        // write data, already in its byte lanes
        logic [`XLEN-1:0]  wdt;
    } bus_req_t;

    ////////////////////
    // bus response
    ////////////////////

    typedef struct packed {
        // response valid, one cycle after request
        logic              vld;
        // access error
        logic              err;
        // read data, zero on writes and errors
        logic [`XLEN-1:0]  rdt;
    } bus_rsp_t;

    // target chosen by the system decoder
    typedef enum logic [1:0] {
        SEL_MEM = 2'd0,
        SEL_PER = 2'd1,
        SEL_ERR = 2'd2
    } bus_sel_t;

endpackage

`default_nettype wire

//--- include/soc_config.svh
// bus widths, address map and gpio register offsets, included by the RTL and the testbench
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

////////////////////
// bus widths
////////////////////

// address and data bus width
`define XLEN 32

// memory word address bits, 1024 words of 4 bytes
`define MEM_ADR 10

// gpio pin count
`define GDW 32

////////////////////
// address map
////////////////////

// data memory window, 4 KiB
`define MEM_BASE 32'h8000_0000

// peripheral window, 256 bytes
`define PER_BASE 32'h8001_0000
// offset bits inside the peripheral window
`define PER_ADR 8

// sub windows, picked by the top two offset bits
`define PER_GPIO 2'b00
`define PER_UART 2'b01

////////////////////
// gpio registers
////////////////////

`define GPIO_OUT 8'h00
`define GPIO_ENA 8'h04
`define GPIO_INP 8'h08

`endif
